//--- Makefile
# Verilator flow for the memory island testbench
VERILATOR ?= verilator
TOP       ?= tb_mem_island
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --timescale 1ns/1ps
PASS_MSG  ?= All tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- hdl/bus_to_mem_adapter.sv
// Four-phase req/ack bus slave that turns each handshake into one memory port transaction
`include "mem_island_defines.svh"

module bus_to_mem_adapter import mem_island_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  bus_req_i,
    input  logic                  bus_we_i,
    input  logic [`MI_ADDR_W-1:0] bus_addr_i,
    input  logic [`MI_DATA_W-1:0] bus_wdata_i,
    output logic                  bus_ack_o,
    output logic [`MI_DATA_W-1:0] bus_rdata_o,
    mem_port_if.initiator         mem
);

    adapter_state_e        state_q, state_d;

    // Latched command and read data
    mem_op_e               op_q;
    logic [`MI_ADDR_W-1:0] addr_q;
    logic [`MI_DATA_W-1:0] wdata_q;
    logic [`MI_DATA_W-1:0] rdata_q;

    // ------------------------------------------------------------------
    // Handshake FSM
    // ------------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        unique case (state_q)
            ST_IDLE:  if (bus_req_i)   state_d = ST_ISSUE;
            ST_ISSUE: if (mem.gnt)     state_d = ST_WAIT;
            ST_WAIT:  if (mem.rvalid)  state_d = ST_ACK;
            // Master must release req before we close the handshake
            ST_ACK:   if (!bus_req_i)  state_d = ST_IDLE;
            default:  state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Command is captured once per handshake, on leaving idle
    always_ff @(posedge clk_i) begin
        if (state_q == ST_IDLE && bus_req_i) begin
            op_q    <= bus_we_i ? MEM_WRITE : MEM_READ;
            addr_q  <= bus_addr_i;
            wdata_q <= bus_wdata_i;
        end
        if (state_q == ST_WAIT && mem.rvalid) begin
            rdata_q <= mem.rdata;
        end
    end

    // ------------------------------------------------------------------
    // Outputs
    // ------------------------------------------------------------------
    assign mem.req     = (state_q == ST_ISSUE);
    assign mem.op      = op_q;
    assign mem.addr    = addr_q;
    assign mem.wdata   = wdata_q;

    assign bus_ack_o   = (state_q == ST_ACK);
    assign bus_rdata_o = rdata_q;

endmodule

//--- hdl/mem_cut.sv
// Spill stage on the memory port, one request entry and one registered response
`include "mem_island_defines.svh"

module mem_cut import mem_island_pkg::*; (
    input  logic          clk_i,
    input  logic          rst_n_i,
    mem_port_if.target    up,
    mem_port_if.initiator dn
);

    logic                  full_q;
    mem_op_e               op_q;
    logic [`MI_ADDR_W-1:0] addr_q;
    logic [`MI_DATA_W-1:0] wdata_q;

    logic                  rvalid_q;
    logic [`MI_DATA_W-1:0] rdata_q;

    // ------------------------------------------------------------------
    // Request entry
    // ------------------------------------------------------------------
    // Accept only into an empty entry, so fill and drain never overlap
    assign up.gnt = !full_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            full_q <= 1'b0;
        end else if (!full_q && up.req) begin
            full_q <= 1'b1;
        end else if (full_q && dn.gnt) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!full_q && up.req) begin
            op_q    <= up.op;
            addr_q  <= up.addr;
            wdata_q <= up.wdata;
        end
    end

    assign dn.req   = full_q;
    assign dn.op    = op_q;
    assign dn.addr  = addr_q;
    assign dn.wdata = wdata_q;

    // ------------------------------------------------------------------
    // Response register
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= dn.rvalid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (dn.rvalid) begin
            rdata_q <= dn.rdata;
        end
    end

    assign up.rvalid = rvalid_q;
    assign up.rdata  = rdata_q;

endmodule

//--- hdl/mem_island_core.sv
// Banked storage core with per-bank round-robin between the bus and direct memory ports
`include "mem_island_defines.svh"

module mem_island_core import mem_island_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    mem_port_if.target bus_port,
    mem_port_if.target dir_port
);

    localparam int BANK_W = $clog2(`MI_NUM_BANKS);
    localparam int ROW_W  = `MI_ADDR_W - BANK_W;

    logic [BANK_W-1:0]       bus_bank, dir_bank;
    logic [ROW_W-1:0]        bus_row, dir_row;

    logic [`MI_NUM_BANKS-1:0] bus_hit, dir_hit;
    logic [`MI_NUM_BANKS-1:0] bus_win, dir_win;
    // Per bank: 0 favours the bus port, 1 favours the direct port
    logic [`MI_NUM_BANKS-1:0] rr_q;

    logic [`MI_DATA_W-1:0]   bank_mem [`MI_NUM_BANKS][`MI_BANK_WORDS];
    logic [`MI_DATA_W-1:0]   bank_rdata_q [`MI_NUM_BANKS];

    // Response routing state
    logic                    bus_gnt_q, dir_gnt_q;
    logic [BANK_W-1:0]       bus_bank_q, dir_bank_q;

    // ------------------------------------------------------------------
    // Address decode and arbitration
    // ------------------------------------------------------------------
    // Word interleaving, low bits pick the bank
    assign bus_bank = bus_port.addr[BANK_W-1:0];
    assign dir_bank = dir_port.addr[BANK_W-1:0];
    assign bus_row  = bus_port.addr[`MI_ADDR_W-1:BANK_W];
    assign dir_row  = dir_port.addr[`MI_ADDR_W-1:BANK_W];

    always_comb begin
        for (int b = 0; b < `MI_NUM_BANKS; b++) begin
            bus_hit[b] = bus_port.req && (bus_bank == BANK_W'(b));
            dir_hit[b] = dir_port.req && (dir_bank == BANK_W'(b));
            bus_win[b] = bus_hit[b] && (!dir_hit[b] || !rr_q[b]);
            dir_win[b] = dir_hit[b] && (!bus_hit[b] || rr_q[b]);
        end
    end

    assign bus_port.gnt = |bus_win;
    assign dir_port.gnt = |dir_win;

    // The port that just won a bank yields it on the next conflict
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rr_q <= '0;
        end else begin
            for (int b = 0; b < `MI_NUM_BANKS; b++) begin
                if (bus_win[b]) begin
                    rr_q[b] <= 1'b1;
                end else if (dir_win[b]) begin
                    rr_q[b] <= 1'b0;
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // Bank access, single cycle
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        for (int b = 0; b < `MI_NUM_BANKS; b++) begin
            if (bus_win[b]) begin
                if (bus_port.op == MEM_WRITE) begin
                    bank_mem[b][bus_row] <= bus_port.wdata;
                end else begin
                    bank_rdata_q[b] <= bank_mem[b][bus_row];
                end
            end else if (dir_win[b]) begin
                if (dir_port.op == MEM_WRITE) begin
                    bank_mem[b][dir_row] <= dir_port.wdata;
                end else begin
                    bank_rdata_q[b] <= bank_mem[b][dir_row];
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // Response routing
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bus_gnt_q <= 1'b0;
            dir_gnt_q <= 1'b0;
        end else begin
            bus_gnt_q <= bus_port.gnt;
            dir_gnt_q <= dir_port.gnt;
        end
    end

    always_ff @(posedge clk_i) begin
        bus_bank_q <= bus_bank;
        dir_bank_q <= dir_bank;
    end

    assign bus_port.rvalid = bus_gnt_q;
    assign bus_port.rdata  = bank_rdata_q[bus_bank_q];
    assign dir_port.rvalid = dir_gnt_q;
    assign dir_port.rdata  = bank_rdata_q[dir_bank_q];

endmodule

//--- hdl/mem_island_defines.svh
// Size definitions for the memory island, included by the package, the RTL and the testbench
`ifndef MEM_ISLAND_DEFINES_SVH
`define MEM_ISLAND_DEFINES_SVH

// ----------------------------------------------------------------------
// Address and data
// ----------------------------------------------------------------------
// Word address, not byte address
`define MI_ADDR_W 10
`define MI_DATA_W 32

// ----------------------------------------------------------------------
// Banking
// ----------------------------------------------------------------------
// Bank select is the address LSB
`define MI_NUM_BANKS 2
// MI_NUM_BANKS * MI_BANK_WORDS covers the whole word address space
`define MI_BANK_WORDS 512

`endif

//--- hdl/mem_island_pkg.sv
// Shared enum types of the memory island, imported by the interface and the RTL modules
`include "mem_island_defines.svh"

package mem_island_pkg;

    // ------------------------------------------------------------------
    // Memory protocol opcode
    // ------------------------------------------------------------------
    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

    // ------------------------------------------------------------------
    // Bus adapter handshake states
    // ------------------------------------------------------------------
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_ISSUE = 2'd1,
        ST_WAIT  = 2'd2,
        ST_ACK   = 2'd3
    } adapter_state_e;

endpackage

//--- hdl/mem_island_top.sv
// Memory island top level, a four-phase bus port and a direct request/grant port on plain pins
`include "mem_island_defines.svh"

module mem_island_top import mem_island_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    // Four-phase bus port
    input  logic                  bus_req_i,
    input  logic                  bus_we_i,
    input  logic [`MI_ADDR_W-1:0] bus_addr_i,
    input  logic [`MI_DATA_W-1:0] bus_wdata_i,
    output logic                  bus_ack_o,
    output logic [`MI_DATA_W-1:0] bus_rdata_o,

    // Direct memory port
    input  logic                  dir_req_i,
    input  logic                  dir_we_i,
    input  logic [`MI_ADDR_W-1:0] dir_addr_i,
    input  logic [`MI_DATA_W-1:0] dir_wdata_i,
    output logic                  dir_gnt_o,
    output logic                  dir_rvalid_o,
    output logic [`MI_DATA_W-1:0] dir_rdata_o
);

    mem_port_if adapter_if ();
    mem_port_if core_bus_if ();
    mem_port_if dir_if ();

    // ------------------------------------------------------------------
    // Bus path, adapter then spill stage
    // ------------------------------------------------------------------
    bus_to_mem_adapter u_adapter (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .bus_req_i   (bus_req_i),
        .bus_we_i    (bus_we_i),
        .bus_addr_i  (bus_addr_i),
        .bus_wdata_i (bus_wdata_i),
        .bus_ack_o   (bus_ack_o),
        .bus_rdata_o (bus_rdata_o),
        .mem         (adapter_if.initiator)
    );

    mem_cut u_cut (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .up      (adapter_if.target),
        .dn      (core_bus_if.initiator)
    );

    // ------------------------------------------------------------------
    // Direct path, pins mapped straight onto the port
    // ------------------------------------------------------------------
    assign dir_if.req   = dir_req_i;
    assign dir_if.op    = dir_we_i ? MEM_WRITE : MEM_READ;
    assign dir_if.addr  = dir_addr_i;
    assign dir_if.wdata = dir_wdata_i;
    assign dir_gnt_o    = dir_if.gnt;
    assign dir_rvalid_o = dir_if.rvalid;
    assign dir_rdata_o  = dir_if.rdata;

    mem_island_core u_core (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .bus_port (core_bus_if.target),
        .dir_port (dir_if.target)
    );

endmodule

//--- hdl/mem_port_if.sv
// Request/grant memory port between island blocks, with initiator and target views
`include "mem_island_defines.svh"

interface mem_port_if import mem_island_pkg::*; ();

    // Request channel, held stable by the initiator until gnt
    logic                  req;
    mem_op_e               op;
    logic [`MI_ADDR_W-1:0] addr;
    logic [`MI_DATA_W-1:0] wdata;

    // Grant and single-cycle response, no back-pressure
    logic                  gnt;
    logic                  rvalid;
    logic [`MI_DATA_W-1:0] rdata;

    modport initiator (
        output req, op, addr, wdata,
        input  gnt, rvalid, rdata
    );

    modport target (
        input  req, op, addr, wdata,
        output gnt, rvalid, rdata
    );

endinterface

//--- sim/tb_mem_island.sv
// Directed testbench for the memory island that runs as top level against a reference memory
`include "mem_island_defines.svh"

module tb_mem_island;
    timeunit 1ns;
    timeprecision 1ps;

    typedef logic [`MI_ADDR_W-1:0] addr_t;
    typedef logic [`MI_DATA_W-1:0] word_t;

    // About 300 transactions at under 10 cycles each leave a wide margin
    localparam int MAX_CYCLES = 20000;
    localparam int WORDS      = `MI_NUM_BANKS * `MI_BANK_WORDS;

    logic  clk;
    logic  rst_n;
    logic  bus_req, bus_we, bus_ack;
    addr_t bus_addr;
    word_t bus_wdata, bus_rdata;
    logic  dir_req, dir_we, dir_gnt, dir_rvalid;
    addr_t dir_addr;
    word_t dir_wdata, dir_rdata;

    word_t  ref_mem [WORDS];
    bit     known [WORDS];
    integer seed;
    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;

    mem_island_top DUT (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .bus_req_i    (bus_req),
        .bus_we_i     (bus_we),
        .bus_addr_i   (bus_addr),
        .bus_wdata_i  (bus_wdata),
        .bus_ack_o    (bus_ack),
        .bus_rdata_o  (bus_rdata),
        .dir_req_i    (dir_req),
        .dir_we_i     (dir_we),
        .dir_addr_i   (dir_addr),
        .dir_wdata_i  (dir_wdata),
        .dir_gnt_o    (dir_gnt),
        .dir_rvalid_o (dir_rvalid),
        .dir_rdata_o  (dir_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic check(input word_t got, input word_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0d ns: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    // ----------------------------------------------------------------------
    // Port drivers that update the model when a transaction is issued
    // ----------------------------------------------------------------------
    task automatic dir_xfer(input bit we, input addr_t addr, input word_t data);
        word_t exp;
        int    waited;
        exp = ref_mem[addr];
        if (we) begin
            ref_mem[addr] = data;
            known[addr]   = 1'b1;
        end
        @(posedge clk);
        #1;
        dir_req   = 1'b1;
        dir_we    = we;
        dir_addr  = addr;
        dir_wdata = data;
        waited    = 0;
        @(negedge clk);
        while (!dir_gnt) begin
            waited++;
            @(negedge clk);
        end
        check(word_t'(waited <= 4), 1, "direct request starved");
        check(word_t'(dir_rvalid), 0, "direct rvalid in grant cycle");
        @(posedge clk);
        #1;
        dir_req = 1'b0;
        @(negedge clk);
        check(word_t'(dir_rvalid), 1, "direct rvalid one cycle after grant");
        if (!we) begin
            check(dir_rdata, exp, "direct read data");
        end
    endtask

    task automatic bus_xfer(input bit we, input addr_t addr, input word_t data);
        word_t exp;
        int    waited;
        exp = ref_mem[addr];
        if (we) begin
            ref_mem[addr] = data;
            known[addr]   = 1'b1;
        end
        @(posedge clk);
        #1;
        check(word_t'(bus_ack), 0, "bus ack high before req");
        bus_req   = 1'b1;
        bus_we    = we;
        bus_addr  = addr;
        bus_wdata = data;
        waited    = 0;
        @(negedge clk);
        while (!bus_ack) begin
            waited++;
            @(negedge clk);
        end
        check(word_t'(waited >= 3), 1, "bus ack too early");
        if (!we) begin
            check(bus_rdata, exp, "bus read data");
        end
        @(posedge clk);
        #1;
        // Ack has to stay up until the master lets go of req
        check(word_t'(bus_ack), 1, "bus ack dropped before req");
        bus_req = 1'b0;
        @(negedge clk);
        while (bus_ack) begin
            @(negedge clk);
        end
    endtask

    // Bus and direct transactions start together and the direct one waits dly edges
    task automatic contend(input bit we, input addr_t b_addr, input addr_t d_addr, input int dly);
        word_t b_data;
        word_t d_data;
        b_data = word_t'($random(seed));
        d_data = word_t'($random(seed));
        fork
            bus_xfer(we, b_addr, b_data);
            begin
                repeat (dly) @(posedge clk);
                dir_xfer(we, d_addr, d_data);
            end
        join
    endtask

    // ----------------------------------------------------------------------
    // Tests
    // ----------------------------------------------------------------------
    task automatic idle_after_reset();
        repeat (5) begin
            @(negedge clk);
            check(word_t'({bus_ack, dir_gnt, dir_rvalid}), 0, "outputs active while idle");
        end
    endtask

    task automatic single_port_rw();
        for (int a = 0; a < 8; a++) begin
            dir_xfer(1'b1, addr_t'(a), word_t'($random(seed)));
        end
        for (int a = 0; a < 8; a++) begin
            dir_xfer(1'b0, addr_t'(a), '0);
        end
        for (int a = 16; a < 24; a++) begin
            bus_xfer(1'b1, addr_t'(a), word_t'($random(seed)));
        end
        for (int a = 16; a < 24; a++) begin
            bus_xfer(1'b0, addr_t'(a), '0);
        end
    endtask

    task automatic cross_port_rw();
        for (int a = 32; a < 34; a++) begin
            bus_xfer(1'b1, addr_t'(a), word_t'($random(seed)));
            dir_xfer(1'b0, addr_t'(a), '0);
        end
        for (int a = 34; a < 36; a++) begin
            dir_xfer(1'b1, addr_t'(a), word_t'($random(seed)));
            bus_xfer(1'b0, addr_t'(a), '0);
        end
    endtask

    task automatic bank_contention();
        // A delay of 2 lines the direct request up with the bus request at the core
        for (int dly = 0; dly <= 2; dly += 2) begin
            contend(1'b1, addr_t'(64), addr_t'(66), dly);
            contend(1'b0, addr_t'(64), addr_t'(66), dly);
            contend(1'b1, addr_t'(68), addr_t'(71), dly);
            contend(1'b0, addr_t'(68), addr_t'(71), dly);
        end
    endtask

    task automatic random_mix();
        bit    port [2];
        bit    we [2];
        addr_t addr [2];
        word_t data [2];
        for (int r = 0; r < 100; r++) begin
            for (int s = 0; s < 2; s++) begin
                port[s] = 1'($random(seed));
                we[s]   = 1'($random(seed));
                addr[s] = addr_t'($random(seed));
                data[s] = word_t'($random(seed));
                // Distinct addresses keep the model independent of completion order
                if (s == 1 && addr[1] == addr[0]) begin
                    addr[1] = addr[0] ^ addr_t'(2);
                end
                if (!known[addr[s]]) begin
                    we[s] = 1'b1;
                end
            end
            fork
                for (int s = 0; s < 2; s++) begin
                    if (port[s]) begin
                        bus_xfer(we[s], addr[s], data[s]);
                    end
                end
                for (int s = 0; s < 2; s++) begin
                    if (!port[s]) begin
                        dir_xfer(we[s], addr[s], data[s]);
                    end
                end
            join
        end
    endtask

    initial begin
        seed      = 32'hc225;
        rst_n     = 1'b0;
        bus_req   = 1'b0;
        bus_we    = 1'b0;
        bus_addr  = '0;
        bus_wdata = '0;
        dir_req   = 1'b0;
        dir_we    = 1'b0;
        dir_addr  = '0;
        dir_wdata = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        idle_after_reset();
        single_port_rw();
        cross_port_rw();
        bank_contention();
        random_mix();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+hdl
hdl/mem_island_pkg.sv
hdl/mem_port_if.sv
hdl/bus_to_mem_adapter.sv
hdl/mem_cut.sv
hdl/mem_island_core.sv
hdl/mem_island_top.sv
sim/tb_mem_island.sv
